// ==== filelist.f ====
src/pipe_pkg.sv
src/stage_tags_if.sv
src/hazard_unit.sv
src/reg_file.sv
src/exec_stage.sv
src/mem_stage.sv
src/pipe_core.sv
test/clk_gen.sv
test/hazard_checker.sv
test/pipe_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pipe_tb -f filelist.f -o pipe_sim

out=$(./obj_dir/pipe_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1

// ==== test/pipe_tb.sv ====
// ####################################################################
// pipeline testbench
// random instruction stream, sequential reference model,
// writeback comparison, hazard checker bind and cycle limit
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module pipe_tb;
	import pipe_pkg::*;

	localparam int n_instr = 400;
	localparam int cycle_limit = 4 * n_instr + 100;

	logic              clk;
	logic              rst_n;
	logic              instr_valid;
	logic [data_w-1:0] instr;
	logic              stall;
	logic              wb_valid;
	logic [reg_w-1:0]  wb_reg;
	logic [data_w-1:0] wb_data;

	// reference model state
	logic [data_w-1:0]       ref_regs [0:15];
	logic [data_w-1:0]       ref_mem [0:15];
	// expected writebacks as {rd, value}
	logic [reg_w+data_w-1:0] exp_q [$];
	logic [reg_w+data_w-1:0] exp_wb;
	logic [31:0]             lcg_state;
	instr_u                  cur;
	instr_u                  prev;
	int                      issued;
	int                      cycles = 0;

	clk_gen #(.period(20)) clk0 (.clk(clk));

	pipe_core #(.mem_depth(16)) dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.stall       (stall),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data)
	);

	bind hazard_unit hazard_checker chk0 (
		.clk              (pipe_tb.clk),
		.rst_n            (pipe_tb.rst_n),
		.ex_mem_dst       (ex_mem.dst),
		.ex_mem_read      (ex_mem.mem_read),
		.ex_mem_write     (ex_mem.mem_write),
		.mem_wb_dst       (mem_wb.dst),
		.mem_wb_reg_write (mem_wb.reg_write),
		.fwd_a            (fwd_a),
		.fwd_b            (fwd_b),
		.fwd_store        (fwd_store),
		.no_op            (no_op),
		.hold             (hold)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// registers 0..3 only, so hazards are dense
	function automatic logic [15:0] make_instr(input logic [31:0] r, input instr_u last);
		logic [3:0] rd;
		logic [3:0] ra;
		logic [3:0] rb;
		op_t        op;
		rd = {2'b00, r[18:17]};
		ra = {2'b00, r[16:15]};
		rb = {2'b00, r[14:13]};
		case (r[22:19])
			4'd0: op = nop;
			4'd1, 4'd2: op = add;
			4'd3: op = sub;
			4'd4: op = and_op;
			4'd5: op = or_op;
			4'd6, 4'd7: op = addi;
			4'd8, 4'd9, 4'd10: op = ld;
			default: op = st;
		endcase
		// right after a load, mostly use the loaded register
		if (last.i.opcode == ld && r[28:27] != 2'b00) begin
			rb = last.i.rd;
			if (r[26]) begin
				op = st;
			end else begin
				op = op_t'({2'b00, r[24:23]} + 4'd1);
				if (r[25]) begin
					ra = last.i.rd;
				end
			end
		end
		// immediate field for addi and ld
		if (op == addi || op == ld) begin
			rb = r[12:9];
		end
		return {op, rd, ra, rb};
	endfunction

	// one instruction in program order
	task automatic run_model(input instr_u w);
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic [data_w-1:0] addr;
		logic [data_w-1:0] res;
		logic              wr;
		a = ref_regs[w.r.rs1];
		b = ref_regs[w.r.rs2];
		addr = a + {12'h000, w.i.imm4};
		res = '0;
		wr = 1'b1;
		case (w.r.opcode)
			add:    res = a + b;
			sub:    res = a - b;
			and_op: res = a & b;
			or_op:  res = a | b;
			addi:   res = addr;
			ld:     res = ref_mem[addr[3:0]];
			st: begin
				ref_mem[a[3:0]] = b;
				wr = 1'b0;
			end
			default: wr = 1'b0;
		endcase
		if (wr && w.r.rd != 4'd0) begin
			ref_regs[w.r.rd] = res;
			exp_q.push_back({w.r.rd, res});
		end
	endtask

	task automatic report_fail(input string line);
		$display("%s", line);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	// outputs are stable mid-cycle
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			assert (wb_reg != '0)
				else report_fail("writeback to register 0");
			assert (exp_q.size() != 0)
				else report_fail("writeback with no instruction left to retire");
			exp_wb = exp_q.pop_front();
			assert (wb_reg == exp_wb[19:16])
				else report_fail($sformatf("FAILED wb_reg expected %h got %h",
					exp_wb[19:16], wb_reg));
			assert (wb_data == exp_wb[15:0])
				else report_fail($sformatf("FAILED wb_data expected %h got %h",
					exp_wb[15:0], wb_data));
		end
		assert (dut0.haz0.chk0.err_count == 0)
			else report_fail("a hazard checker assertion failed");
	end

	always @(posedge clk) begin
		cycles++;
		assert (cycles < cycle_limit)
			else report_fail("timeout, the pipeline stopped making progress");
	end

	initial begin
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		lcg_state = 32'hdf60;
		prev = '0;
		issued = 0;
		for (int i = 0; i < 16; i++) begin
			ref_regs[i] = '0;
			ref_mem[i] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		while (issued < n_instr) begin
			lcg_state = lcg_next(lcg_state);
			if (lcg_state[31:29] == 3'b000) begin
				// empty slot with junk on the bus
				instr_valid = 1'b0;
				instr = lcg_state[23:8];
				@(posedge clk);
				#1;
			end else begin
				cur = make_instr(lcg_state, prev);
				instr_valid = 1'b1;
				instr = cur;
				// held while stall is up
				@(negedge clk);
				while (stall) begin
					@(negedge clk);
				end
				// taken at the coming edge
				run_model(cur);
				prev = cur;
				issued++;
				@(posedge clk);
				#1;
			end
		end
		instr_valid = 1'b0;
		instr = '0;
		// wait until every expected writeback has retired
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		// a few more cycles for any stray writeback
		repeat (6) @(negedge clk);
		#1;
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/hazard_checker.sv ====
// ####################################################################
// concurrent assertions on the hazard unit
// forwarding from r0, stall pattern, store forwarding, reset quiet
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module hazard_checker (
	input logic                       clk,
	input logic                       rst_n,
	input logic [pipe_pkg::reg_w-1:0] ex_mem_dst,
	input logic                       ex_mem_read,
	input logic                       ex_mem_write,
	input logic [pipe_pkg::reg_w-1:0] mem_wb_dst,
	input logic                       mem_wb_reg_write,
	input pipe_pkg::fwd_sel_t         fwd_a,
	input pipe_pkg::fwd_sel_t         fwd_b,
	input logic                       fwd_store,
	input logic [3:0]                 no_op,
	input logic [3:0]                 hold
);
	import pipe_pkg::*;

	// failures seen so far, read by the testbench
	int unsigned err_count = 0;
	// cycles since reset was released, saturating
	logic [1:0] since_rst;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			since_rst <= '0;
		end else if (since_rst != 2'd3) begin
			since_rst <= since_rst + 2'd1;
		end
	end

	// only a load in EX/MEM may stall
	a_stall_needs_load: assert property (@(posedge clk) disable iff (!rst_n)
		!ex_mem_read |-> (hold == 4'b0000) && (no_op == 4'b0000))
	else begin
		err_count++;
		$error("stall raised without a load in EX/MEM");
	end

	// bubble into EX/MEM goes with ID/EX and input hold, MEM/WB keeps moving
	a_stall_pattern: assert property (@(posedge clk) disable iff (!rst_n)
		no_op[2] |-> hold[1] && hold[0] && !no_op[3] && (hold[3:2] == 2'b00))
	else begin
		err_count++;
		$error("load-use bubble without the matching hold bits");
	end

	// a load-use stall lasts one cycle
	a_stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		hold[0] |=> !hold[0])
	else begin
		err_count++;
		$error("stall held for more than one cycle");
	end

	a_store_fwd_needs_store: assert property (@(posedge clk) disable iff (!rst_n)
		fwd_store |-> ex_mem_write)
	else begin
		err_count++;
		$error("store data forwarded with no store in EX/MEM");
	end

	// r0 as destination never feeds anything
	a_no_ex_fwd_from_r0: assert property (@(posedge clk) disable iff (!rst_n)
		(ex_mem_dst == '0) |->
			(fwd_a != fwd_ex_mem) && (fwd_b != fwd_ex_mem) && !no_op[2])
	else begin
		err_count++;
		$error("EX/MEM forward or stall from register 0");
	end

	a_no_wb_fwd_from_r0: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_wb_dst == '0) |->
			(fwd_a != fwd_mem_wb) && (fwd_b != fwd_mem_wb) && !fwd_store)
	else begin
		err_count++;
		$error("MEM/WB forward from register 0");
	end

	// pipeline is empty right after reset
	a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		(since_rst < 2'd2) |-> !hold[0] && !mem_wb_reg_write)
	else begin
		err_count++;
		$error("stall or writeback right after reset");
	end

	a_no_early_wb: assert property (@(posedge clk) disable iff (!rst_n)
		(since_rst == 2'd2) |-> !mem_wb_reg_write)
	else begin
		err_count++;
		$error("writeback before any instruction could reach MEM/WB");
	end

endmodule

`default_nettype wire

// ==== test/clk_gen.sv ====
// ####################################################################
// free running testbench clock, 50 percent duty cycle
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
	parameter int period = 20
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== src/pipe_core.sv ====
// ##################################################################
// pipeline top level
// decode, ID/EX, EX/MEM and MEM/WB registers, writeback select,
// hazard unit, register file, execute and memory stages
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module pipe_core #(
	parameter int mem_depth = 16
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        instr_valid,
	input  logic [pipe_pkg::data_w-1:0] instr,
	output logic                        stall,
	output logic                        wb_valid,
	output logic [pipe_pkg::reg_w-1:0]  wb_reg,
	output logic [pipe_pkg::data_w-1:0] wb_data
);
	import pipe_pkg::*;

	stage_tags_if id_ex_tags ();
	stage_tags_if ex_mem_tags ();
	stage_tags_if mem_wb_tags ();

	// decode outputs
	instr_u            dec;
	logic              id_valid;
	op_t               id_op;
	logic [reg_w-1:0]  id_dst;
	logic [reg_w-1:0]  id_src1;
	logic [reg_w-1:0]  id_src2;
	logic              id_mem_read;
	logic              id_mem_write;
	logic              id_reg_write;
	logic [data_w-1:0] id_imm;
	logic [data_w-1:0] rf_data1;
	logic [data_w-1:0] rf_data2;

	// ID/EX payload
	op_t               ex_op;
	logic [data_w-1:0] ex_rs1_val;
	logic [data_w-1:0] ex_rs2_val;
	logic [data_w-1:0] ex_imm;
	logic [data_w-1:0] alu_result;
	logic [data_w-1:0] alu_store_data;

	// EX/MEM and MEM/WB payload
	logic [data_w-1:0] mem_result;
	logic [data_w-1:0] mem_store_data;
	logic [data_w-1:0] wb_result;
	logic [data_w-1:0] load_data;

	// hazard unit outputs
	fwd_sel_t          fwd_a;
	fwd_sel_t          fwd_b;
	logic              fwd_store;
	logic [3:0]        no_op;
	logic [3:0]        hold;

	assign dec = instr;
	assign id_valid = instr_valid && !no_op[0];
	assign id_imm = {{(data_w-4){1'b0}}, dec.i.imm4};

	// decode into tags, a dropped or empty slot becomes a bubble
	always_comb begin
		id_op = nop;
		id_dst = '0;
		id_src1 = '0;
		id_src2 = '0;
		id_mem_read = 1'b0;
		id_mem_write = 1'b0;
		id_reg_write = 1'b0;
		if (id_valid) begin
			case (dec.r.opcode)
				add, sub, and_op, or_op: begin
					id_op = dec.r.opcode;
					id_dst = dec.r.rd;
					id_src1 = dec.r.rs1;
					id_src2 = dec.r.rs2;
					id_reg_write = 1'b1;
				end
				addi, ld: begin
					id_op = dec.i.opcode;
					id_dst = dec.i.rd;
					id_src1 = dec.i.rs1;
					id_mem_read = (dec.i.opcode == ld);
					id_reg_write = 1'b1;
				end
				st: begin
					id_op = st;
					id_src1 = dec.r.rs1;
					id_src2 = dec.r.rs2;
					id_mem_write = 1'b1;
				end
				default: id_op = nop;
			endcase
		end
		// writes to r0 are dropped here
		id_reg_write = id_reg_write && (id_dst != '0);
	end

	// ID/EX control
	always_ff @(posedge clk) begin
		if (!rst_n || no_op[1]) begin
			ex_op <= nop;
			{id_ex_tags.dst, id_ex_tags.src1, id_ex_tags.src2} <= '0;
			{id_ex_tags.mem_read, id_ex_tags.mem_write, id_ex_tags.reg_write} <= '0;
		end else if (!hold[1]) begin
			ex_op <= id_op;
			{id_ex_tags.dst, id_ex_tags.src1, id_ex_tags.src2} <=
				{id_dst, id_src1, id_src2};
			{id_ex_tags.mem_read, id_ex_tags.mem_write, id_ex_tags.reg_write} <=
				{id_mem_read, id_mem_write, id_reg_write};
		end
	end

	// ID/EX operands
	always_ff @(posedge clk) begin
		if (hold[1]) begin
			// a waiting consumer catches the older write leaving WB
			if (fwd_a == fwd_mem_wb) begin
				ex_rs1_val <= wb_data;
			end
			if (fwd_b == fwd_mem_wb) begin
				ex_rs2_val <= wb_data;
			end
		end else begin
			ex_rs1_val <= rf_data1;
			ex_rs2_val <= rf_data2;
			ex_imm <= id_imm;
		end
	end

	// EX/MEM and MEM/WB control
	always_ff @(posedge clk) begin
		if (!rst_n || no_op[2]) begin
			{ex_mem_tags.dst, ex_mem_tags.src1, ex_mem_tags.src2} <= '0;
			{ex_mem_tags.mem_read, ex_mem_tags.mem_write, ex_mem_tags.reg_write} <= '0;
		end else if (!hold[2]) begin
			{ex_mem_tags.dst, ex_mem_tags.src1, ex_mem_tags.src2} <=
				{id_ex_tags.dst, id_ex_tags.src1, id_ex_tags.src2};
			{ex_mem_tags.mem_read, ex_mem_tags.mem_write, ex_mem_tags.reg_write} <=
				{id_ex_tags.mem_read, id_ex_tags.mem_write, id_ex_tags.reg_write};
		end
		if (!rst_n || no_op[3]) begin
			{mem_wb_tags.dst, mem_wb_tags.src1, mem_wb_tags.src2} <= '0;
			{mem_wb_tags.mem_read, mem_wb_tags.mem_write, mem_wb_tags.reg_write} <= '0;
		end else begin
			{mem_wb_tags.dst, mem_wb_tags.src1, mem_wb_tags.src2} <=
				{ex_mem_tags.dst, ex_mem_tags.src1, ex_mem_tags.src2};
			{mem_wb_tags.mem_read, mem_wb_tags.mem_write, mem_wb_tags.reg_write} <=
				{ex_mem_tags.mem_read, ex_mem_tags.mem_write, ex_mem_tags.reg_write};
		end
	end

	// EX/MEM and MEM/WB payload
	always_ff @(posedge clk) begin
		if (!hold[2]) begin
			mem_result <= alu_result;
			mem_store_data <= alu_store_data;
		end
		wb_result <= mem_result;
	end

	// writeback select, loads take the registered memory word
	assign wb_data = mem_wb_tags.mem_read ? load_data : wb_result;
	assign wb_valid = mem_wb_tags.reg_write;
	assign wb_reg = mem_wb_tags.dst;
	assign stall = hold[0];

	hazard_unit haz0 (
		.id_ex     (id_ex_tags),
		.ex_mem    (ex_mem_tags),
		.mem_wb    (mem_wb_tags),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b),
		.fwd_store (fwd_store),
		.no_op     (no_op),
		.hold      (hold)
	);

	reg_file rf0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr1 (dec.r.rs1),
		.rd_addr2 (dec.r.rs2),
		.rd_data1 (rf_data1),
		.rd_data2 (rf_data2),
		.wr_en    (mem_wb_tags.reg_write),
		.wr_addr  (mem_wb_tags.dst),
		.wr_data  (wb_data)
	);

	exec_stage ex0 (
		.op            (ex_op),
		.rs1_val       (ex_rs1_val),
		.rs2_val       (ex_rs2_val),
		.imm           (ex_imm),
		.ex_mem_result (mem_result),
		.mem_wb_result (wb_data),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.result        (alu_result),
		.store_data    (alu_store_data)
	);

	mem_stage #(
		.mem_depth (mem_depth)
	) mem0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (mem_result),
		.store_data (mem_store_data),
		.wb_data    (wb_data),
		.fwd_store  (fwd_store),
		.write      (ex_mem_tags.mem_write),
		.load_data  (load_data)
	);

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
// ##################################################################
// memory stage
// data memory with registered read, store data forwarding from WB
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
	parameter int mem_depth = 16
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [pipe_pkg::data_w-1:0] addr,
	input  logic [pipe_pkg::data_w-1:0] store_data,
	input  logic [pipe_pkg::data_w-1:0] wb_data,
	input  logic                        fwd_store,
	input  logic                        write,
	output logic [pipe_pkg::data_w-1:0] load_data
);
	import pipe_pkg::*;

	localparam int addr_w = $clog2(mem_depth);

	logic [data_w-1:0] mem [0:mem_depth-1];
	logic [addr_w-1:0] idx;
	logic [data_w-1:0] wr_word;

	// word index from the low address bits
	assign idx = addr[addr_w-1:0];

	// loaded value still in WB replaces stale store data
	assign wr_word = fwd_store ? wb_data : store_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < mem_depth; i++) begin
				mem[i] <= '0;
			end
		end else if (write) begin
			mem[idx] <= wr_word;
		end
	end

	// read data lands together with MEM/WB
	always_ff @(posedge clk) begin
		load_data <= mem[idx];
	end

endmodule

`default_nettype wire

// ==== src/exec_stage.sv ====
// ##################################################################
// execute stage
// operand forwarding muxes and the ALU
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
	input  pipe_pkg::op_t               op,
	input  logic [pipe_pkg::data_w-1:0] rs1_val,
	input  logic [pipe_pkg::data_w-1:0] rs2_val,
	input  logic [pipe_pkg::data_w-1:0] imm,
	input  logic [pipe_pkg::data_w-1:0] ex_mem_result,
	input  logic [pipe_pkg::data_w-1:0] mem_wb_result,
	input  pipe_pkg::fwd_sel_t          fwd_a,
	input  pipe_pkg::fwd_sel_t          fwd_b,
	output logic [pipe_pkg::data_w-1:0] result,
	output logic [pipe_pkg::data_w-1:0] store_data
);
	import pipe_pkg::*;

	// one operand, from the register read or a later stage
	function automatic logic [data_w-1:0] pick(
		input fwd_sel_t          sel,
		input logic [data_w-1:0] reg_val,
		input logic [data_w-1:0] ex_val,
		input logic [data_w-1:0] wb_val
	);
		case (sel)
			fwd_ex_mem: return ex_val;
			fwd_mem_wb: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	logic [data_w-1:0] opnd_a;
	logic [data_w-1:0] opnd_b;

	assign opnd_a = pick(fwd_a, rs1_val, ex_mem_result, mem_wb_result);
	assign opnd_b = pick(fwd_b, rs2_val, ex_mem_result, mem_wb_result);

	always_comb begin
		case (op)
			add:    result = opnd_a + opnd_b;
			sub:    result = opnd_a - opnd_b;
			and_op: result = opnd_a & opnd_b;
			or_op:  result = opnd_a | opnd_b;
			// effective address or immediate sum
			addi, ld: result = opnd_a + imm;
			// store address is rs1 alone
			st:     result = opnd_a;
			default: result = '0;
		endcase
	end

	// store value, already forwarded
	assign store_data = opnd_b;

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// ##################################################################
// register file, 16 x 16
// two read ports, one write port with write-through, r0 is zero
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [pipe_pkg::reg_w-1:0]  rd_addr1,
	input  logic [pipe_pkg::reg_w-1:0]  rd_addr2,
	output logic [pipe_pkg::data_w-1:0] rd_data1,
	output logic [pipe_pkg::data_w-1:0] rd_data2,
	input  logic                        wr_en,
	input  logic [pipe_pkg::reg_w-1:0]  wr_addr,
	input  logic [pipe_pkg::data_w-1:0] wr_data
);
	import pipe_pkg::*;

	logic [data_w-1:0] regs [0:(1 << reg_w)-1];

	// r0 never gets written
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << reg_w); i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// same-cycle write shows up on the read port
	assign rd_data1 = (rd_addr1 == '0) ? '0 :
		((wr_en && (wr_addr == rd_addr1)) ? wr_data : regs[rd_addr1]);
	assign rd_data2 = (rd_addr2 == '0) ? '0 :
		((wr_en && (wr_addr == rd_addr2)) ? wr_data : regs[rd_addr2]);

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
// ##################################################################
// hazard detection
// EX-EX and MEM-EX operand forwarding, MEM-MEM store forwarding,
// load-to-use stall with per-register bubble and hold vectors
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	stage_tags_if.watch         id_ex,
	stage_tags_if.watch         ex_mem,
	stage_tags_if.watch         mem_wb,
	output pipe_pkg::fwd_sel_t  fwd_a,
	output pipe_pkg::fwd_sel_t  fwd_b,
	output logic                fwd_store,
	output logic [3:0]          no_op,
	output logic [3:0]          hold
);
	import pipe_pkg::*;

	// a later stage writing a nonzero register that an earlier one reads
	function automatic logic tag_hit(
		input logic [reg_w-1:0] dst,
		input logic [reg_w-1:0] src,
		input logic             wr
	);
		return wr && (dst != '0) && (dst == src);
	endfunction

	logic ex_hit_a;
	logic ex_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;
	logic load_use;

	// producer one ahead of the ALU operands
	assign ex_hit_a = tag_hit(ex_mem.dst, id_ex.src1, ex_mem.reg_write);
	assign ex_hit_b = tag_hit(ex_mem.dst, id_ex.src2, ex_mem.reg_write);

	// producer two ahead
	assign wb_hit_a = tag_hit(mem_wb.dst, id_ex.src1, mem_wb.reg_write);
	assign wb_hit_b = tag_hit(mem_wb.dst, id_ex.src2, mem_wb.reg_write);

	// a load in EX/MEM has no data yet, so it cannot forward
	assign load_use = ex_mem.mem_read && (ex_hit_a || ex_hit_b);

	// EX/MEM is the newer value and wins over MEM/WB
	assign fwd_a = (ex_hit_a && !ex_mem.mem_read) ? fwd_ex_mem :
		(wb_hit_a ? fwd_mem_wb : fwd_rf);
	assign fwd_b = (ex_hit_b && !ex_mem.mem_read) ? fwd_ex_mem :
		(wb_hit_b ? fwd_mem_wb : fwd_rf);

	// store data in MEM taken from the instruction in WB
	assign fwd_store = ex_mem.mem_write &&
		tag_hit(mem_wb.dst, ex_mem.src2, mem_wb.reg_write);

	// bit 0 input, bit 1 ID/EX, bit 2 EX/MEM, bit 3 MEM/WB
	// stall: bubble into EX/MEM, consumer and input wait one cycle
	assign no_op = load_use ? 4'b0100 : 4'b0000;
	assign hold  = load_use ? 4'b0011 : 4'b0000;

endmodule

`default_nettype wire

// ==== src/stage_tags_if.sv ====
// ##################################################################
// hazard tags of one pipeline register
// owner side loads them, watch side is the hazard unit
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

interface stage_tags_if;

	// destination and source register numbers
	logic [pipe_pkg::reg_w-1:0] dst;
	logic [pipe_pkg::reg_w-1:0] src1;
	logic [pipe_pkg::reg_w-1:0] src2;
	// memory and writeback control
	logic                       mem_read;
	logic                       mem_write;
	logic                       reg_write;

	modport owner (
		output dst, src1, src2, mem_read, mem_write, reg_write
	);

	modport watch (
		input dst, src1, src2, mem_read, mem_write, reg_write
	);

endinterface

`default_nettype wire

// ==== src/pipe_pkg.sv ====
// ##################################################################
// shared definitions for the pipeline
// data and register number widths, opcodes, both instruction
// formats, the instruction union and the operand source select
// ##################################################################
`default_nettype none

package pipe_pkg;

	// datapath and register number widths
	localparam int data_w = 16;
	localparam int reg_w = 4;

	// opcodes live in the top nibble of every instruction
	typedef enum logic [3:0] {
		nop    = 4'd0,
		add    = 4'd1,
		sub    = 4'd2,
		and_op = 4'd3,
		or_op  = 4'd4,
		addi   = 4'd5,
		ld     = 4'd6,
		st     = 4'd7
	} op_t;

	// register format: add, sub, and, or, st (rs2 is store data)
	typedef struct packed {
		op_t              opcode;
		logic [reg_w-1:0] rd;
		logic [reg_w-1:0] rs1;
		logic [reg_w-1:0] rs2;
	} r_fmt_t;

	// immediate format: addi, ld (imm4 zero extended)
	typedef struct packed {
		op_t              opcode;
		logic [reg_w-1:0] rd;
		logic [reg_w-1:0] rs1;
		logic [3:0]       imm4;
	} i_fmt_t;

	// one 16-bit word, two views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

	// where an ALU operand comes from
	typedef enum logic [1:0] {
		fwd_rf     = 2'd0,
		fwd_ex_mem = 2'd1,
		fwd_mem_wb = 2'd2
	} fwd_sel_t;

endpackage

`default_nettype wire
